/* flist.f */
src/rv32_isa_pkg.sv
src/dispatch_pkg.sv
src/opcode_decode.sv
src/funct_decode.sv
src/dispatch_decoder.sv
tb/tb_clock.sv
tb/decoder_asserts.sv
tb/decoder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dispatch decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module decoder_tb -o decoder_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/decoder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

/* src/dispatch_decoder.sv */
// Dispatch stage decoder
// decodes one fetch packet per cycle into a registered decode packet

`timescale 1ns/10ps

module dispatch_decoder (
    input  logic                         clock,
    input  logic                         reset,
    input  dispatch_pkg::fetch_packet_t  fetch_packet,
    output dispatch_pkg::decode_packet_t decode_packet
);
    dispatch_pkg::inst_class_t    inst_class;
    dispatch_pkg::route_ctrl_t    route;
    dispatch_pkg::func_ctrl_t     func;
    dispatch_pkg::decode_packet_t decode_next;

    opcode_decode u_opcode_decode (
        .fetch_packet (fetch_packet),
        .inst_class   (inst_class),
        .route        (route)
    );

    funct_decode u_funct_decode (
        .inst       (fetch_packet.inst),
        .inst_class (inst_class),
        .func       (func)
    );

    assign decode_next = '{route: route, func: func};

    ////////////////////////////////////////////////////////////////////////////
    // output register, one cycle into the pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset)
            decode_packet <= dispatch_pkg::noop_packet;
        else
            decode_packet <= decode_next;   // no stall, always overwritten
    end

endmodule

/* src/dispatch_pkg.sv */
// Dispatch stage control types
// select encodings and the packets crossing the fetch/dispatch boundary

package dispatch_pkg;

    typedef enum logic [1:0] {
        opa_is_rs1, opa_is_pc, opa_is_zero
    } opa_sel_t;

    typedef enum logic [2:0] {
        opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_b_imm, opb_is_u_imm, opb_is_j_imm
    } opb_sel_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_func_t;

    typedef enum logic [1:0] {fu_alu, fu_ls, fu_branch} fu_sel_t;
    typedef enum logic [1:0] {op_alu, op_ls, op_br} op_sel_t;

    // load widths first, then store widths
    typedef enum logic [2:0] {lb, lh, lw, lbu, lhu, sb, sh, sw} ls_sel_t;

    typedef enum logic [3:0] {
        cls_none, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_load, cls_store, cls_op_imm, cls_op, cls_system, cls_illegal
    } inst_class_t;

    typedef struct packed {
        logic                valid;
        rv32_isa_pkg::inst_t inst;
    } fetch_packet_t;

    typedef struct packed {
        fu_sel_t                fu_sel;
        op_sel_t                op_sel;
        opa_sel_t               opa_select;
        opb_sel_t               opb_select;
        rv32_isa_pkg::reg_idx_t dest_reg;
        rv32_isa_pkg::reg_idx_t src_reg_1;
        rv32_isa_pkg::reg_idx_t src_reg_2;
        logic                   rd_mem;
        logic                   wr_mem;
        logic                   cond_branch;
        logic                   uncond_branch;
    } route_ctrl_t;

    typedef struct packed {
        alu_func_t alu_func;
        ls_sel_t   ls_sel;
        logic      csr_op;
        logic      halt;
        logic      illegal;
        logic      valid_inst;
    } func_ctrl_t;

    typedef struct packed {
        route_ctrl_t route;
        func_ctrl_t  func;
    } decode_packet_t;

    localparam route_ctrl_t noop_route = '{
        fu_sel: fu_alu, op_sel: op_alu,
        opa_select: opa_is_rs1, opb_select: opb_is_rs2,
        dest_reg: rv32_isa_pkg::zero_reg,
        src_reg_1: rv32_isa_pkg::zero_reg,
        src_reg_2: rv32_isa_pkg::zero_reg,
        default: 1'b0
    };

    localparam func_ctrl_t noop_func = '{alu_func: alu_add, ls_sel: lw, default: 1'b0};

    localparam decode_packet_t noop_packet = '{route: noop_route, func: noop_func};

endpackage

/* src/funct_decode.sv */
// Sub-function decoder
// resolves funct3/funct7 into alu function, load/store width, system
// flags and legality of the instruction

`timescale 1ns/10ps

module funct_decode (
    input  rv32_isa_pkg::inst_t       inst,
    input  dispatch_pkg::inst_class_t inst_class,
    output dispatch_pkg::func_ctrl_t  func
);
    rv32_isa_pkg::funct3_t funct3;
    rv32_isa_pkg::funct7_t funct7;
    logic                  funct7_zero;
    logic                  funct7_alt;

    assign funct3      = rv32_isa_pkg::get_funct3(inst);
    assign funct7      = rv32_isa_pkg::get_funct7(inst);
    assign funct7_zero = (funct7 == '0);
    assign funct7_alt  = (funct7 == rv32_isa_pkg::funct7_alt);

    always_comb begin
        func = dispatch_pkg::noop_func;   // add covers address generation
        case (inst_class)
            dispatch_pkg::cls_op_imm: begin
                case (funct3)
                    3'b000: func.alu_func = dispatch_pkg::alu_add;
                    3'b010: func.alu_func = dispatch_pkg::alu_slt;
                    3'b011: func.alu_func = dispatch_pkg::alu_sltu;
                    3'b100: func.alu_func = dispatch_pkg::alu_xor;
                    3'b110: func.alu_func = dispatch_pkg::alu_or;
                    3'b111: func.alu_func = dispatch_pkg::alu_and;
                    3'b001: begin
                        func.alu_func = dispatch_pkg::alu_sll;
                        func.illegal  = !funct7_zero;   // shamt[5] set too
                    end
                    default: begin   // srli / srai
                        func.alu_func = funct7_alt ? dispatch_pkg::alu_sra
                                                   : dispatch_pkg::alu_srl;
                        func.illegal  = !(funct7_zero || funct7_alt);
                    end
                endcase
            end

            dispatch_pkg::cls_op: begin
                case (funct3)
                    3'b000: func.alu_func = funct7_alt ? dispatch_pkg::alu_sub
                                                       : dispatch_pkg::alu_add;
                    3'b001: func.alu_func = dispatch_pkg::alu_sll;
                    3'b010: func.alu_func = dispatch_pkg::alu_slt;
                    3'b011: func.alu_func = dispatch_pkg::alu_sltu;
                    3'b100: func.alu_func = dispatch_pkg::alu_xor;
                    3'b101: func.alu_func = funct7_alt ? dispatch_pkg::alu_sra
                                                       : dispatch_pkg::alu_srl;
                    3'b110: func.alu_func = dispatch_pkg::alu_or;
                    default: func.alu_func = dispatch_pkg::alu_and;
                endcase
                // the M extension (funct7 = 1) falls out here as well
                if (funct7_alt)
                    func.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                else
                    func.illegal = !funct7_zero;
            end

            dispatch_pkg::cls_load: begin
                case (funct3)
                    3'b000:  func.ls_sel = dispatch_pkg::lb;
                    3'b001:  func.ls_sel = dispatch_pkg::lh;
                    3'b010:  func.ls_sel = dispatch_pkg::lw;
                    3'b100:  func.ls_sel = dispatch_pkg::lbu;
                    3'b101:  func.ls_sel = dispatch_pkg::lhu;
                    default: func.illegal = 1'b1;
                endcase
            end

            dispatch_pkg::cls_store: begin
                case (funct3)
                    3'b000:  func.ls_sel = dispatch_pkg::sb;
                    3'b001:  func.ls_sel = dispatch_pkg::sh;
                    3'b010:  func.ls_sel = dispatch_pkg::sw;
                    default: func.illegal = 1'b1;
                endcase
            end

            dispatch_pkg::cls_branch: func.illegal = (funct3[2:1] == 2'b01);
            dispatch_pkg::cls_jalr:   func.illegal = (funct3 != '0);

            dispatch_pkg::cls_system: begin
                if (inst == rv32_isa_pkg::inst_wfi)
                    func.halt = 1'b1;
                else if (funct3 == rv32_isa_pkg::funct3_csrrw ||
                         funct3 == rv32_isa_pkg::funct3_csrrs ||
                         funct3 == rv32_isa_pkg::funct3_csrrc)
                    func.csr_op = 1'b1;
                else
                    func.illegal = 1'b1;   // ecall, ebreak, csr immediates
            end

            dispatch_pkg::cls_illegal: func.illegal = 1'b1;

            default: ;   // none, lui, auipc, jal
        endcase

        func.valid_inst = (inst_class != dispatch_pkg::cls_none) && !func.illegal;
    end

endmodule

/* src/opcode_decode.sv */
// Major opcode decoder
// classifies the instruction and sets unit, operand and register routing

`timescale 1ns/10ps

module opcode_decode (
    input  dispatch_pkg::fetch_packet_t fetch_packet,
    output dispatch_pkg::inst_class_t   inst_class,
    output dispatch_pkg::route_ctrl_t   route
);
    rv32_isa_pkg::opcode_t  opcode;
    rv32_isa_pkg::reg_idx_t rd;
    rv32_isa_pkg::reg_idx_t rs1;
    rv32_isa_pkg::reg_idx_t rs2;

    assign opcode = rv32_isa_pkg::get_opcode(fetch_packet.inst);
    assign rd     = rv32_isa_pkg::get_rd(fetch_packet.inst);
    assign rs1    = rv32_isa_pkg::get_rs1(fetch_packet.inst);
    assign rs2    = rv32_isa_pkg::get_rs2(fetch_packet.inst);

    ////////////////////////////////////////////////////////////////////////////
    // classification
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!fetch_packet.valid) begin
            inst_class = dispatch_pkg::cls_none;   // bubble
        end else begin
            case (opcode)
                rv32_isa_pkg::op_lui:    inst_class = dispatch_pkg::cls_lui;
                rv32_isa_pkg::op_auipc:  inst_class = dispatch_pkg::cls_auipc;
                rv32_isa_pkg::op_jal:    inst_class = dispatch_pkg::cls_jal;
                rv32_isa_pkg::op_jalr:   inst_class = dispatch_pkg::cls_jalr;
                rv32_isa_pkg::op_branch: inst_class = dispatch_pkg::cls_branch;
                rv32_isa_pkg::op_load:   inst_class = dispatch_pkg::cls_load;
                rv32_isa_pkg::op_store:  inst_class = dispatch_pkg::cls_store;
                rv32_isa_pkg::op_op_imm: inst_class = dispatch_pkg::cls_op_imm;
                rv32_isa_pkg::op_op:     inst_class = dispatch_pkg::cls_op;
                rv32_isa_pkg::op_system: inst_class = dispatch_pkg::cls_system;
                default:                 inst_class = dispatch_pkg::cls_illegal;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // routing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        route = dispatch_pkg::noop_route;   // none, system and illegal keep this
        case (inst_class)
            dispatch_pkg::cls_lui: begin
                route.dest_reg   = rd;
                route.opa_select = dispatch_pkg::opa_is_zero;
                route.opb_select = dispatch_pkg::opb_is_u_imm;
            end
            dispatch_pkg::cls_auipc: begin
                route.dest_reg   = rd;
                route.opa_select = dispatch_pkg::opa_is_pc;
                route.opb_select = dispatch_pkg::opb_is_u_imm;
            end
            dispatch_pkg::cls_jal: begin
                route.fu_sel        = dispatch_pkg::fu_branch;
                route.op_sel        = dispatch_pkg::op_br;
                route.dest_reg      = rd;
                route.opa_select    = dispatch_pkg::opa_is_pc;
                route.opb_select    = dispatch_pkg::opb_is_j_imm;
                route.uncond_branch = 1'b1;
            end
            dispatch_pkg::cls_jalr: begin
                route.fu_sel        = dispatch_pkg::fu_branch;
                route.op_sel        = dispatch_pkg::op_br;
                route.dest_reg      = rd;
                route.src_reg_1     = rs1;   // target base
                route.opb_select    = dispatch_pkg::opb_is_i_imm;
                route.uncond_branch = 1'b1;
            end
            dispatch_pkg::cls_branch: begin
                route.fu_sel      = dispatch_pkg::fu_branch;
                route.op_sel      = dispatch_pkg::op_br;
                route.src_reg_1   = rs1;
                route.src_reg_2   = rs2;
                route.opa_select  = dispatch_pkg::opa_is_pc;
                route.opb_select  = dispatch_pkg::opb_is_b_imm;
                route.cond_branch = 1'b1;
            end
            dispatch_pkg::cls_load: begin
                route.fu_sel     = dispatch_pkg::fu_ls;
                route.op_sel     = dispatch_pkg::op_ls;
                route.dest_reg   = rd;
                route.src_reg_1  = rs1;
                route.opb_select = dispatch_pkg::opb_is_i_imm;
                route.rd_mem     = 1'b1;
            end
            dispatch_pkg::cls_store: begin
                // address computed on the alu, data from rs2
                route.op_sel     = dispatch_pkg::op_ls;
                route.src_reg_1  = rs1;
                route.src_reg_2  = rs2;
                route.opb_select = dispatch_pkg::opb_is_s_imm;
                route.wr_mem     = 1'b1;
            end
            dispatch_pkg::cls_op_imm: begin
                route.dest_reg   = rd;
                route.src_reg_1  = rs1;
                route.opb_select = dispatch_pkg::opb_is_i_imm;
            end
            dispatch_pkg::cls_op: begin
                route.dest_reg  = rd;
                route.src_reg_1 = rs1;
                route.src_reg_2 = rs2;
            end
            default: ;
        endcase
    end

endmodule

/* src/rv32_isa_pkg.sv */
// RV32I instruction set definitions
// field widths, field types, major opcodes and the few sub-function codes
// that the dispatch decoder has to recognise

package rv32_isa_pkg;

    localparam int xlen      = 32;   // instruction width
    localparam int reg_idx_w = 5;    // architectural register index

    typedef logic [xlen-1:0]      inst_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;

    localparam reg_idx_t zero_reg = '0;   // x0

    ////////////////////////////////////////////////////////////////////////////
    // major opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_op_imm = 7'b0010011;
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_system = 7'b1110011;

    // funct7 of SUB, SRA and SRAI
    localparam funct7_t funct7_alt = 7'b0100000;

    // zicsr register forms, immediate forms are not supported
    localparam funct3_t funct3_csrrw = 3'b001;
    localparam funct3_t funct3_csrrs = 3'b010;
    localparam funct3_t funct3_csrrc = 3'b011;

    localparam inst_t inst_wfi = 32'h1050_0073;

    ////////////////////////////////////////////////////////////////////////////
    // field extraction
    ////////////////////////////////////////////////////////////////////////////

    function automatic opcode_t get_opcode(inst_t inst);
        return inst[6:0];
    endfunction

    function automatic reg_idx_t get_rd(inst_t inst);
        return inst[11:7];
    endfunction

    function automatic reg_idx_t get_rs1(inst_t inst);
        return inst[19:15];
    endfunction

    function automatic reg_idx_t get_rs2(inst_t inst);
        return inst[24:20];
    endfunction

    function automatic funct3_t get_funct3(inst_t inst);
        return inst[14:12];
    endfunction

    // also the upper immediate bits of shift-immediates
    function automatic funct7_t get_funct7(inst_t inst);
        return inst[31:25];
    endfunction

endpackage

/* tb/decoder_asserts.sv */
// Decode packet assertions
// consistency of the registered flags of the dispatch decoder

`timescale 1ns/10ps

module decoder_asserts (
    input logic                         clock,
    input logic                         reset,
    input dispatch_pkg::decode_packet_t decode_packet
);
    property valid_not_illegal;
        @(posedge clock) decode_packet.func.valid_inst |-> !decode_packet.func.illegal;
    endproperty

    property system_flags_exclusive;
        @(posedge clock) $onehot0({decode_packet.func.halt, decode_packet.func.csr_op,
                                   decode_packet.func.illegal});
    endproperty

    property single_mem_access;
        @(posedge clock) !(decode_packet.route.rd_mem && decode_packet.route.wr_mem);
    endproperty

    property quiet_after_reset;
        @(posedge clock) reset |=> !decode_packet.func.valid_inst;
    endproperty

    assert property (valid_not_illegal) else $error("valid_inst set with illegal");
    assert property (system_flags_exclusive) else $error("halt, csr_op, illegal overlap");
    assert property (single_mem_access) else $error("rd_mem and wr_mem both high");
    assert property (quiet_after_reset) else $error("valid_inst high after reset");

endmodule

/* tb/decoder_tb.sv */
// Dispatch decoder testbench
// directed tests against a reference decode model, then a random stream

`timescale 1ns/10ps

module decoder_tb;
    localparam int max_cycles = 400;   // about 160 cycles of tests plus margin

    logic                         clock;
    logic                         reset;
    dispatch_pkg::fetch_packet_t  fetch_packet;
    dispatch_pkg::decode_packet_t decode_packet;

    integer seed = 92;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     cycles = 0;
    rv32_isa_pkg::inst_t legal_q[$];

    tb_clock u_clock (.clock(clock), .reset(reset));

    dispatch_decoder uut (
        .clock         (clock),
        .reset         (reset),
        .fetch_packet  (fetch_packet),
        .decode_packet (decode_packet)
    );

    bind dispatch_decoder decoder_asserts u_asserts (
        .clock(clock), .reset(reset), .decode_packet(decode_packet)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference decode
    ////////////////////////////////////////////////////////////////////////////

    function automatic dispatch_pkg::decode_packet_t model(logic valid, logic [31:0] w);
        dispatch_pkg::decode_packet_t p;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       bad;
        f3 = w[14:12];
        f7 = w[31:25];
        bad = 1'b0;
        p = '0;
        p.func.ls_sel = dispatch_pkg::lw;
        if (!valid)
            return p;
        case (w[6:0])
            7'h37, 7'h17: begin   // lui, auipc
                p.route.dest_reg = w[11:7];
                p.route.opa_select = (w[5]) ? dispatch_pkg::opa_is_zero : dispatch_pkg::opa_is_pc;
                p.route.opb_select = dispatch_pkg::opb_is_u_imm;
            end
            7'h6f, 7'h67: begin   // jal, jalr
                p.route.fu_sel = dispatch_pkg::fu_branch;
                p.route.op_sel = dispatch_pkg::op_br;
                p.route.dest_reg = w[11:7];
                p.route.uncond_branch = 1'b1;
                if (w[3]) begin
                    p.route.opa_select = dispatch_pkg::opa_is_pc;
                    p.route.opb_select = dispatch_pkg::opb_is_j_imm;
                end else begin
                    p.route.src_reg_1 = w[19:15];
                    p.route.opb_select = dispatch_pkg::opb_is_i_imm;
                    bad = (f3 != 3'd0);
                end
            end
            7'h63: begin
                p.route.fu_sel = dispatch_pkg::fu_branch;
                p.route.op_sel = dispatch_pkg::op_br;
                p.route.src_reg_1 = w[19:15];
                p.route.src_reg_2 = w[24:20];
                p.route.opa_select = dispatch_pkg::opa_is_pc;
                p.route.opb_select = dispatch_pkg::opb_is_b_imm;
                p.route.cond_branch = 1'b1;
                bad = (f3 == 3'd2 || f3 == 3'd3);
            end
            7'h03: begin
                p.route.fu_sel = dispatch_pkg::fu_ls;
                p.route.op_sel = dispatch_pkg::op_ls;
                p.route.dest_reg = w[11:7];
                p.route.src_reg_1 = w[19:15];
                p.route.opb_select = dispatch_pkg::opb_is_i_imm;
                p.route.rd_mem = 1'b1;
                case (f3)
                    3'd0: p.func.ls_sel = dispatch_pkg::lb;
                    3'd1: p.func.ls_sel = dispatch_pkg::lh;
                    3'd2: p.func.ls_sel = dispatch_pkg::lw;
                    3'd4: p.func.ls_sel = dispatch_pkg::lbu;
                    3'd5: p.func.ls_sel = dispatch_pkg::lhu;
                    default: bad = 1'b1;
                endcase
            end
            7'h23: begin
                p.route.op_sel = dispatch_pkg::op_ls;
                p.route.src_reg_1 = w[19:15];
                p.route.src_reg_2 = w[24:20];
                p.route.opb_select = dispatch_pkg::opb_is_s_imm;
                p.route.wr_mem = 1'b1;
                case (f3)
                    3'd0: p.func.ls_sel = dispatch_pkg::sb;
                    3'd1: p.func.ls_sel = dispatch_pkg::sh;
                    3'd2: p.func.ls_sel = dispatch_pkg::sw;
                    default: bad = 1'b1;
                endcase
            end
            7'h13, 7'h33: begin
                p.route.dest_reg = w[11:7];
                p.route.src_reg_1 = w[19:15];
                if (w[5])
                    p.route.src_reg_2 = w[24:20];
                else
                    p.route.opb_select = dispatch_pkg::opb_is_i_imm;
                case (f3)
                    3'd0: p.func.alu_func = (w[5] && f7 == 7'h20) ? dispatch_pkg::alu_sub
                                                                   : dispatch_pkg::alu_add;
                    3'd1: p.func.alu_func = dispatch_pkg::alu_sll;
                    3'd2: p.func.alu_func = dispatch_pkg::alu_slt;
                    3'd3: p.func.alu_func = dispatch_pkg::alu_sltu;
                    3'd4: p.func.alu_func = dispatch_pkg::alu_xor;
                    3'd5: p.func.alu_func = (f7 == 7'h20) ? dispatch_pkg::alu_sra
                                                          : dispatch_pkg::alu_srl;
                    3'd6: p.func.alu_func = dispatch_pkg::alu_or;
                    default: p.func.alu_func = dispatch_pkg::alu_and;
                endcase
                if (w[5])
                    bad = (f7 == 7'h20) ? !(f3 == 3'd0 || f3 == 3'd5) : (f7 != 7'h0);
                else if (f3 == 3'd1)
                    bad = (f7 != 7'h0);
                else if (f3 == 3'd5)
                    bad = !(f7 == 7'h0 || f7 == 7'h20);
            end
            7'h73: begin
                if (w == 32'h1050_0073)
                    p.func.halt = 1'b1;
                else if (f3 >= 3'd1 && f3 <= 3'd3)
                    p.func.csr_op = 1'b1;
                else
                    bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        p.func.illegal = bad;
        p.func.valid_inst = !bad;
        return p;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] make_word(logic [6:0] op, logic [2:0] f3, logic [6:0] f7,
                                              logic fix_f7);
        logic [31:0] w;
        w = $random(seed);
        w[6:0] = op;
        w[14:12] = f3;
        if (fix_f7)
            w[31:25] = f7;
        return w;
    endfunction

    // full: whole packet; otherwise only csr_op, halt, illegal, valid_inst
    task automatic decode_one(string name, logic [31:0] w, logic full);
        dispatch_pkg::decode_packet_t exp;
        exp = model(1'b1, w);
        @(posedge clock);
        #1 fetch_packet = '{valid: 1'b1, inst: w};
        @(posedge clock);
        #1;
        if (full) begin
            compare(name, exp, decode_packet);
            legal_q.push_back(w);
        end else begin
            compare(name, 4'b0010, {decode_packet.func.csr_op, decode_packet.func.halt,
                                    decode_packet.func.illegal, decode_packet.func.valid_inst});
        end
    endtask

    task automatic finish_test(string name);
        tests++;
        $display("test %s done, %0d errors so far", name, errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        // a legal add sits on the input, only reset keeps it off the output
        fetch_packet = '{valid: 1'b1, inst: make_word(7'h33, 3'd0, 7'h00, 1'b1)};
        @(posedge clock);
        #1 compare("reset_during", model(1'b0, 32'h0), decode_packet);
        wait (!reset);
        fetch_packet = '0;
        @(posedge clock);
        #1 compare("reset_after", model(1'b0, 32'h0), decode_packet);
        finish_test("reset_state");
    endtask

    task automatic alu_ops();
        for (int f3 = 0; f3 < 8; f3++) begin
            decode_one("op", make_word(7'h33, f3, 7'h00, 1'b1), 1'b1);
            decode_one("op_imm", make_word(7'h13, f3, 7'h00, f3 == 1 || f3 == 5), 1'b1);
        end
        decode_one("sub", make_word(7'h33, 3'd0, 7'h20, 1'b1), 1'b1);
        decode_one("sra", make_word(7'h33, 3'd5, 7'h20, 1'b1), 1'b1);
        decode_one("srai", make_word(7'h13, 3'd5, 7'h20, 1'b1), 1'b1);
        finish_test("alu_ops");
    endtask

    task automatic memory_ops();
        int ld_f3[5] = '{0, 1, 2, 4, 5};
        foreach (ld_f3[i])
            decode_one("load", make_word(7'h03, ld_f3[i], 7'h0, 1'b0), 1'b1);
        for (int f3 = 0; f3 < 3; f3++)
            decode_one("store", make_word(7'h23, f3, 7'h0, 1'b0), 1'b1);
        finish_test("memory_ops");
    endtask

    task automatic control_flow();
        int br_f3[6] = '{0, 1, 4, 5, 6, 7};
        foreach (br_f3[i])
            decode_one("branch", make_word(7'h63, br_f3[i], 7'h0, 1'b0), 1'b1);
        decode_one("jal", make_word(7'h6f, $random(seed), 7'h0, 1'b0), 1'b1);
        decode_one("jalr", make_word(7'h67, 3'd0, 7'h0, 1'b0), 1'b1);
        decode_one("lui", make_word(7'h37, $random(seed), 7'h0, 1'b0), 1'b1);
        decode_one("auipc", make_word(7'h17, $random(seed), 7'h0, 1'b0), 1'b1);
        finish_test("control_flow");
    endtask

    task automatic system_illegal();
        for (int f3 = 1; f3 < 4; f3++)
            decode_one("csr", make_word(7'h73, f3, 7'h0, 1'b0), 1'b1);
        decode_one("wfi", 32'h1050_0073, 1'b1);
        for (int f3 = 0; f3 < 4; f3++)
            decode_one("mul_family", make_word(7'h33, f3, 7'h01, 1'b1), 1'b0);
        decode_one("load_f3_3", make_word(7'h03, 3'd3, 7'h0, 1'b0), 1'b0);
        decode_one("load_f3_6", make_word(7'h03, 3'd6, 7'h0, 1'b0), 1'b0);
        decode_one("load_f3_7", make_word(7'h03, 3'd7, 7'h0, 1'b0), 1'b0);
        decode_one("unknown_op", make_word(7'h7f, 3'd0, 7'h0, 1'b0), 1'b0);
        decode_one("custom_op", make_word(7'h0b, 3'd2, 7'h0, 1'b0), 1'b0);
        finish_test("system_illegal");
    endtask

    task automatic streaming();
        dispatch_pkg::decode_packet_t exp;
        dispatch_pkg::fetch_packet_t  next;
        logic                         have_prev;
        have_prev = 1'b0;
        for (int i = 0; i <= 40; i++) begin
            @(posedge clock);
            #1;
            next.valid = ($random(seed) % 4) != 0;
            next.inst = legal_q[$unsigned($random(seed)) % legal_q.size()];
            fetch_packet = next;
            #1;   // new input already applied, output must still show the previous one
            if (have_prev)
                compare("stream", exp, decode_packet);
            exp = model(next.valid, next.inst);
            have_prev = 1'b1;
        end
        @(posedge clock);
        #1 compare("stream", exp, decode_packet);
        finish_test("streaming");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: tests did not complete within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        fetch_packet = '0;
        reset_state();
        alu_ops();
        memory_ops();
        control_flow();
        system_illegal();
        streaming();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
// Testbench clock and reset
// 10 ns clock, reset held high for the first 4 rising edges

`timescale 1ns/10ps

module tb_clock (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule
